// File: common/pdp8_pkg.sv
// ################################################
// Bit 0 is the most significant bit, as on the PDP-8
// ################################################
`default_nettype none

package pdp8_pkg;

    typedef logic [0:11] word_t;    // One machine word
    typedef logic [0:11] addr_t;    // 4K word address
    typedef logic [0:2]  opcode_t;  // Major opcode field

    typedef enum logic [4:0] {
        F0, FW, F1, F2, F3,       // Fetch
        D0, DW, D1, D2, D3,       // Defer
        E0, EW, E1, E2, E3,       // Execute
        H0, HW,                   // Halted
        DB0, DB1, DB2             // Data break
    } major_state_t;

    localparam opcode_t OP_AND = 3'o0;
    localparam opcode_t OP_TAD = 3'o1;
    localparam opcode_t OP_ISZ = 3'o2;
    localparam opcode_t OP_DCA = 3'o3;
    localparam opcode_t OP_JMS = 3'o4;
    localparam opcode_t OP_JMP = 3'o5;
    localparam opcode_t OP_IOT = 3'o6;
    localparam opcode_t OP_OPR = 3'o7;

    localparam int IND_BIT  = 3;    // Indirect addressing
    localparam int PAGE_BIT = 4;    // Current page when set
    localparam int GRP_BIT  = 3;    // Operate group, 0 is group 1
    localparam int CLA_BIT  = 4;
    localparam int CMA_BIT  = 6;
    localparam int IAC_BIT  = 11;
    localparam int HLT_BIT  = 10;   // Group 2 only
    localparam int GRP3_BIT = 11;   // Set for the MQ group, clear in group 2

    localparam int MEM_WORDS = 4096;

endpackage

`default_nettype wire

// File: sequencer/major_state.sv
// ################################################
// Data breaks are taken at F3, D3, E3 and while halted
// No interrupts, EAE or panel trigger cycles
// ################################################
`default_nettype none

module major_state (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  halt,
    input  logic                  single_step,
    input  logic                  cont,
    input  logic                  data_break,
    input  logic                  to_disk,
    input  pdp8_pkg::word_t       ir,
    output pdp8_pkg::major_state_t state,
    output logic                  break_in_prog,
    output logic                  halted
);
    import pdp8_pkg::*;

    major_state_t ret_state;    // Where a data break returns to
    major_state_t cycle_next;   // Successor at the end of a major cycle
    opcode_t      op;
    logic         is_hlt;
    logic         step_hold;

    assign op = opcode_t'(ir[0:2]);
    assign is_hlt = (op == OP_OPR) && ir[GRP_BIT] && !ir[GRP3_BIT] && ir[HLT_BIT];
    assign step_hold = single_step && !cont;

    always_comb
    begin
        case (state)
            F3:
            begin
                if (is_hlt)
                    cycle_next = H0;
                else if (op == OP_OPR || op == OP_IOT)
                    cycle_next = F0;        // Operate done in F2, IOT ignored
                else if (ir[IND_BIT])
                    cycle_next = D0;
                else if (op == OP_JMP)
                    cycle_next = F0;        // JMP direct needs no execute
                else
                    cycle_next = E0;
            end
            D3:      cycle_next = E0;
            default: cycle_next = F0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= H0;
            ret_state <= H0;
            break_in_prog <= 1'b0;
            halted <= 1'b1;
        end
        else
        begin
            case (state)
                F0:
                begin
                    if (step_hold)
                        state <= F0;
                    else if (halt && !cont)
                    begin
                        state <= H0;
                        halted <= 1'b1;
                    end
                    else
                        state <= FW;
                end
                FW: state <= F1;
                F1: state <= F2;
                F2: state <= F3;

                // Shared end of fetch, defer and execute
                F3, D3, E3:
                begin
                    if (data_break && cycle_next != H0)
                    begin
                        ret_state <= cycle_next;
                        state <= DB0;
                        break_in_prog <= 1'b1;
                    end
                    else
                    begin
                        state <= cycle_next;
                        if (cycle_next == H0)
                            halted <= 1'b1;
                    end
                end

                D0: state <= step_hold ? D0 : DW;
                DW: state <= D1;
                D1: state <= D2;
                D2: state <= D3;

                E0: state <= step_hold ? E0 : EW;
                EW: state <= E1;
                E1: state <= E2;
                E2: state <= E3;

                H0: state <= HW;
                HW:
                begin
                    if (data_break)
                    begin
                        ret_state <= cont ? F0 : H0;    // A cont pulse is not lost
                        state <= DB0;
                        break_in_prog <= 1'b1;
                        halted <= !cont;
                    end
                    else if (cont)
                    begin
                        state <= F0;
                        halted <= 1'b0;
                    end
                    else
                        state <= H0;
                end

                DB0: state <= DB1;
                DB1:
                begin
                    if (to_disk)
                        state <= DB2;               // Read needs one more cycle
                    else
                    begin
                        state <= ret_state;
                        break_in_prog <= 1'b0;
                    end
                end
                DB2:
                begin
                    state <= ret_state;
                    break_in_prog <= 1'b0;
                end

                default: state <= H0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/cpu_datapath.sv
// ################################################
// No link, so TAD carries are dropped
// Memory reads return data two states after the address
// ################################################
`default_nettype none

module cpu_datapath (
    input  logic                   clk,
    input  logic                   reset,
    input  pdp8_pkg::major_state_t state,
    input  pdp8_pkg::word_t        mem_rdata,
    output pdp8_pkg::addr_t        mem_addr,
    output pdp8_pkg::word_t        mem_wdata,
    output logic                   mem_we,
    output pdp8_pkg::word_t        ir,
    output pdp8_pkg::word_t        ac,
    output pdp8_pkg::addr_t        pc
);
    import pdp8_pkg::*;

    addr_t   ma;
    word_t   mb;
    word_t   mb_inc;
    word_t   opr_ac;        // AC after group 1 operate
    opcode_t op;
    logic    jmp_direct;

    assign op = opcode_t'(ir[0:2]);
    assign mb_inc = mb + word_t'(1);
    assign jmp_direct = (op == OP_JMP) && !ir[IND_BIT];

    assign mem_addr = (state == F0) ? pc : ma;  // MA follows PC after F0
    assign mem_we = (state == E2) && (op == OP_ISZ || op == OP_DCA || op == OP_JMS);

    always_comb
    begin
        case (op)
            OP_ISZ:  mem_wdata = mb_inc;
            OP_JMS:  mem_wdata = word_t'(pc);       // Return address
            default: mem_wdata = ac;
        endcase
    end

    // CLA, then CMA, then IAC
    always_comb
    begin
        opr_ac = ac;
        if (ir[CLA_BIT])
            opr_ac = '0;
        if (ir[CMA_BIT])
            opr_ac = ~opr_ac;
        if (ir[IAC_BIT])
            opr_ac = opr_ac + word_t'(1);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= '0;
            ac <= '0;
            ir <= '0;
        end
        else
        begin
            case (state)
                F1:
                begin
                    ir <= mem_rdata;
                    pc <= pc + addr_t'(1);
                end
                F2: if (op == OP_OPR && !ir[GRP_BIT]) ac <= opr_ac;
                F3: if (jmp_direct) pc <= ma;
                E2:
                begin
                    case (op)
                        OP_AND: ac <= ac & mb;
                        OP_TAD: ac <= ac + mb;
                        OP_ISZ: if (mb_inc == '0) pc <= pc + addr_t'(1);   // Skip
                        OP_DCA: ac <= '0;
                        OP_JMS: pc <= ma + addr_t'(1);
                        OP_JMP: pc <= ma;                   // JMP indirect
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            F0: ma <= pc;
            F2: ma <= ir[PAGE_BIT] ? {ma[0:4], ir[5:11]} : {5'b00000, ir[5:11]};
            D2: ma <= mem_rdata;        // Pointer word
            E1: mb <= mem_rdata;        // Operand
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/break_channel.sv
// ################################################
// One request at a time, no new brk_req before brk_done
// ################################################
`default_nettype none

module break_channel (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   brk_req,
    input  logic                   to_disk_in,
    input  pdp8_pkg::addr_t        brk_addr,
    input  pdp8_pkg::word_t        brk_wdata,
    input  pdp8_pkg::major_state_t state,
    input  pdp8_pkg::word_t        mem_rdata,
    output logic                   data_break,
    output logic                   to_disk,
    output logic                   brk_done,
    output pdp8_pkg::addr_t        brk_addr_q,
    output pdp8_pkg::word_t        brk_wdata_q,
    output pdp8_pkg::word_t        brk_rdata
);
    import pdp8_pkg::*;

    logic finish;

    assign finish = data_break && ((state == DB1 && !to_disk) || state == DB2);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            data_break <= 1'b0;
            to_disk <= 1'b0;
            brk_done <= 1'b0;
        end
        else
        begin
            brk_done <= finish;
            if (brk_req)
            begin
                data_break <= 1'b1;
                to_disk <= to_disk_in;      // Set means memory is read
            end
            else if (finish)
                data_break <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (brk_req)
        begin
            brk_addr_q <= brk_addr;
            brk_wdata_q <= brk_wdata;
        end
        if (state == DB2)
            brk_rdata <= mem_rdata;     // Address was given in DB1
    end

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
// ################################################
// Break side writes only in DB1 of a write break
// ################################################
`default_nettype none

module mem_arbiter (
    input  logic                   break_in_prog,
    input  logic                   to_disk,
    input  pdp8_pkg::addr_t        cpu_addr,
    input  pdp8_pkg::addr_t        brk_addr_q,
    input  pdp8_pkg::word_t        cpu_wdata,
    input  pdp8_pkg::word_t        brk_wdata_q,
    input  logic                   cpu_we,
    input  pdp8_pkg::major_state_t state,
    output pdp8_pkg::addr_t        mem_addr,
    output pdp8_pkg::word_t        mem_wdata,
    output logic                   mem_we
);
    import pdp8_pkg::*;

    logic brk_we;

    assign brk_we = (state == DB1) && !to_disk;

    assign mem_addr = break_in_prog ? brk_addr_q : cpu_addr;
    assign mem_wdata = break_in_prog ? brk_wdata_q : cpu_wdata;
    assign mem_we = break_in_prog ? brk_we : cpu_we;

endmodule

`default_nettype wire

// File: rtl/core_mem.sv
// ################################################
// Read during write returns the old word
// ################################################
`default_nettype none

module core_mem (
    input  logic            clk,
    input  pdp8_pkg::addr_t addr,
    input  pdp8_pkg::word_t wdata,
    input  logic            we,
    output pdp8_pkg::word_t rdata
);
    import pdp8_pkg::*;

    word_t mem [0:MEM_WORDS-1];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];     // One cycle latency
    end

endmodule

`default_nettype wire

// File: rtl/pdp8_top.sv
// ################################################
// Memory is not cleared at reset, load it by breaks
// ################################################
`default_nettype none

module pdp8_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            halt,
    input  logic            single_step,
    input  logic            cont,
    input  logic            brk_req,
    input  logic            to_disk,
    input  pdp8_pkg::addr_t brk_addr,
    input  pdp8_pkg::word_t brk_wdata,
    output logic            brk_done,
    output pdp8_pkg::word_t brk_rdata,
    output pdp8_pkg::word_t ac,
    output pdp8_pkg::addr_t pc,
    output logic            halted
);
    import pdp8_pkg::*;

    major_state_t state;
    word_t        ir;
    logic         break_in_prog;
    logic         data_break;
    logic         brk_to_disk;
    addr_t        brk_addr_q;
    word_t        brk_wdata_q;
    addr_t        cpu_addr;
    word_t        cpu_wdata;
    logic         cpu_we;
    addr_t        mem_addr;
    word_t        mem_wdata;
    logic         mem_we;
    word_t        mem_rdata;

    major_state u_major_state (
        .clk(clk), .reset(reset), .halt(halt), .single_step(single_step),
        .cont(cont), .data_break(data_break), .to_disk(brk_to_disk), .ir(ir),
        .state(state), .break_in_prog(break_in_prog), .halted(halted)
    );

    cpu_datapath u_cpu_datapath (
        .clk(clk), .reset(reset), .state(state), .mem_rdata(mem_rdata),
        .mem_addr(cpu_addr), .mem_wdata(cpu_wdata), .mem_we(cpu_we),
        .ir(ir), .ac(ac), .pc(pc)
    );

    break_channel u_break_channel (
        .clk(clk), .reset(reset), .brk_req(brk_req), .to_disk_in(to_disk),
        .brk_addr(brk_addr), .brk_wdata(brk_wdata), .state(state),
        .mem_rdata(mem_rdata), .data_break(data_break), .to_disk(brk_to_disk),
        .brk_done(brk_done), .brk_addr_q(brk_addr_q), .brk_wdata_q(brk_wdata_q),
        .brk_rdata(brk_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .break_in_prog(break_in_prog), .to_disk(brk_to_disk),
        .cpu_addr(cpu_addr), .brk_addr_q(brk_addr_q),
        .cpu_wdata(cpu_wdata), .brk_wdata_q(brk_wdata_q), .cpu_we(cpu_we),
        .state(state), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we)
    );

    core_mem u_core_mem (
        .clk(clk), .addr(mem_addr), .wdata(mem_wdata), .we(mem_we), .rdata(mem_rdata)
    );

endmodule

`default_nettype wire

// File: tests/clock_gen.sv
// ################################################
// Free-running clock, period 4 time units
// ################################################
`default_nettype none

module clock_gen (
    output logic clk
);

    initial
        clk = 1'b0;

    always #2 clk = ~clk;   // Half period

endmodule

`default_nettype wire

// File: tests/tb_top.sv
// ################################################
// Programs run in page 0 with their data at 0100-0177 octal
// Memory is loaded and read back only through data breaks
// ################################################
`default_nettype none

module tb_top;

    localparam int INSN_MAX = 75;   // Single step weighted three times
    localparam int BRK_MAX  = 95;
    localparam int LIMIT    = 2 * (INSN_MAX * 20 + BRK_MAX * 6) + 100;  // Two-fold margin

    logic        clk;
    logic        reset;
    logic        halt;
    logic        single_step;
    logic        cont;
    logic        brk_req;
    logic        to_disk;
    logic [11:0] brk_addr;
    logic [11:0] brk_wdata;
    logic        brk_done;
    logic [11:0] brk_rdata;
    logic [11:0] ac;
    logic [11:0] pc;
    logic        halted;

    logic [11:0] shadow [0:4095];
    logic [11:0] addrs [0:7];
    logic [11:0] model_ac;
    logic [11:0] model_pc;
    logic [11:0] loc;               // Next word to assemble
    logic [11:0] trace_pc [$];      // PC after each instruction
    int          trace_cyc [$];     // Major cycles per instruction
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          cycles;

    clock_gen u_clock_gen (.clk(clk));

    pdp8_top dut (
        .clk(clk), .reset(reset), .halt(halt), .single_step(single_step),
        .cont(cont), .brk_req(brk_req), .to_disk(to_disk), .brk_addr(brk_addr),
        .brk_wdata(brk_wdata), .brk_done(brk_done), .brk_rdata(brk_rdata),
        .ac(ac), .pc(pc), .halted(halted)
    );

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > LIMIT)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic draw(output logic [11:0] v);
        rng = xorshift(rng);
        v = rng[11:0];
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(input string name, input logic [11:0] got,
                             input logic [11:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("Error at %0t: %s = %o, expected %o", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            $display("At %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic wait_done(output logic [11:0] data);
        int n;
        n = 0;
        do
        begin
            next_cycle();
            n++;
        end
        while (!brk_done && n < 30);
        check_true(brk_done, "brk_done did not arrive within 30 cycles");
        data = brk_rdata;   // Meaningful for reads only
    endtask

    task automatic brk_write(input logic [11:0] a, input logic [11:0] d);
        logic [11:0] ignored;
        brk_addr = a;
        brk_wdata = d;
        to_disk = 1'b0;
        brk_req = 1'b1;
        next_cycle();
        brk_req = 1'b0;
        wait_done(ignored);
        shadow[a] = d;
    endtask

    task automatic brk_read(input logic [11:0] a, output logic [11:0] d);
        brk_addr = a;
        to_disk = 1'b1;
        brk_req = 1'b1;
        next_cycle();
        brk_req = 1'b0;
        wait_done(d);
    endtask

    task automatic check_mem(input logic [11:0] a);
        logic [11:0] v;
        brk_read(a, v);
        check_val("brk_rdata", v, shadow[a]);
    endtask

    task automatic emit(input logic [11:0] w);
        brk_write(loc, w);
        loc = loc + 12'd1;
    endtask

    // Instruction-level PDP-8 without link that runs on the shadow memory up to HLT
    task automatic model_run();
        logic [11:0] ir;
        logic [11:0] ea;
        logic [11:0] at;
        int          cyc;
        logic        stop;
        trace_pc.delete();
        trace_cyc.delete();
        stop = 1'b0;
        while (!stop)
        begin
            at = model_pc;
            ir = shadow[at];
            model_pc = model_pc + 12'd1;
            ea = ir[7] ? {at[11:7], ir[6:0]} : {5'b00000, ir[6:0]};
            cyc = 1;
            if (ir[11:9] == 3'o7)
            begin
                if (!ir[8])
                begin
                    if (ir[7])
                        model_ac = '0;
                    if (ir[5])
                        model_ac = ~model_ac;
                    if (ir[0])
                        model_ac = model_ac + 12'd1;
                end
                else if (!ir[0] && ir[1])
                    stop = 1'b1;                    // HLT
            end
            else if (ir[11:9] != 3'o6)
            begin
                if (ir[8])
                begin
                    ea = shadow[ea];
                    cyc++;
                end
                if (ir[11:9] != 3'o5 || ir[8])
                    cyc++;                          // Execute cycle
                case (ir[11:9])
                    3'o0: model_ac = model_ac & shadow[ea];
                    3'o1: model_ac = model_ac + shadow[ea];
                    3'o2:
                    begin
                        shadow[ea] = shadow[ea] + 12'd1;
                        if (shadow[ea] == 12'd0)
                            model_pc = model_pc + 12'd1;
                    end
                    3'o3:
                    begin
                        shadow[ea] = model_ac;
                        model_ac = '0;
                    end
                    3'o4:
                    begin
                        shadow[ea] = model_pc;
                        model_pc = ea + 12'd1;
                    end
                    default: model_pc = ea;
                endcase
            end
            trace_pc.push_back(model_pc);
            trace_cyc.push_back(cyc);
            if (trace_pc.size() > 300)
            begin
                check_true(1'b0, "model ran 300 instructions without reaching HLT");
                stop = 1'b1;
            end
        end
    endtask

    task automatic release_halt();
        cont = 1'b1;            // Held until HW sees it
        do
            next_cycle();
        while (halted);
        cont = 1'b0;
    endtask

    task automatic run_to_halt();
        release_halt();
        while (!halted)
            next_cycle();
        check_val("ac", ac, model_ac);
        check_val("pc", pc, model_pc);
    endtask

    task automatic pulse_cont();
        next_cycle();
        cont = 1'b1;
        next_cycle();
        cont = 1'b0;
        repeat (6) next_cycle();    // Lets one major cycle complete
    endtask

    task automatic load_straight();
        logic [11:0] r;
        loc = model_pc;
        draw(r);
        brk_write(12'o100, r);
        draw(r);
        brk_write(12'o101, r);
        draw(r);
        brk_write(12'o102, r);
        emit(12'o1100);     // TAD A
        emit(12'o0102);     // AND M
        emit(12'o3103);     // DCA R1
        emit(12'o1101);     // TAD B
        emit(12'o7041);     // CMA IAC
        emit(12'o3104);     // DCA R2
        emit(12'o7240);     // CLA CMA
        emit(12'o1100);
        emit(12'o3105);     // DCA R3
        emit(12'o7201);     // CLA IAC
        emit(12'o1101);
        emit(12'o7402);     // HLT
    endtask

    task automatic check_straight();
        check_mem(12'o103);
        check_mem(12'o104);
        check_mem(12'o105);
    endtask

    task automatic side_breaks();
        logic [11:0] a;
        logic [11:0] d;
        for (int i = 0; i < 6; i++)
        begin
            draw(a);
            draw(d);
            a = {1'b1, a[10:0]};    // Upper half is unused by the programs
            brk_write(a, d);
            check_mem(a);
            repeat (d[1:0]) next_cycle();
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - err_before);
    endtask

    initial
    begin
        int          e0;
        logic [11:0] r;
        logic [11:0] v;
        reset = 1'b1;
        halt = 1'b0;
        single_step = 1'b0;
        cont = 1'b0;
        brk_req = 1'b0;
        to_disk = 1'b0;
        brk_addr = '0;
        brk_wdata = '0;
        rng = 32'h8b40;
        errors = 0;
        checks = 0;
        model_ac = '0;
        model_pc = '0;
        repeat (10) next_cycle();
        reset = 1'b0;

        e0 = errors;
        for (int i = 0; i < 8; i++)
        begin
            draw(addrs[i]);
            draw(r);
            brk_write(addrs[i], r);
            check_true(halted, "halted fell during a break write");
        end
        for (int i = 0; i < 8; i++)
        begin
            brk_read(addrs[i], v);
            check_val("brk_rdata", v, shadow[addrs[i]]);
            check_true(halted, "halted fell during a break read");
        end
        end_test("break write and read while halted", e0);

        e0 = errors;
        load_straight();
        model_run();
        run_to_halt();
        check_straight();
        end_test("straight-line program", e0);

        e0 = errors;
        loc = model_pc;
        draw(r);
        brk_write(12'o111, 12'd0 - {9'd0, r[2:0]} - 12'd1);    // Count of -1 to -8
        draw(r);
        brk_write(12'o112, r);
        emit(12'o7200);                     // CLA, AC still holds the last result
        emit(12'o1111);                     // TAD INIT
        emit(12'o3110);                     // DCA CNT
        emit(12'o1112);                     // TAD STEP
        emit(12'o2110);                     // ISZ CNT
        emit(12'o5000 | (loc - 12'd2));     // JMP back to TAD STEP
        emit(12'o7402);
        model_run();
        run_to_halt();
        brk_read(12'o110, v);
        check_val("brk_rdata", v, 12'd0);
        end_test("ISZ loop", e0);

        e0 = errors;
        loc = model_pc;
        draw(r);
        brk_write(12'o121, r);
        brk_write(12'o120, 12'o160);        // Pointer to the subroutine
        brk_write(12'o160, 12'o0000);       // Return slot
        brk_write(12'o161, 12'o1121);
        brk_write(12'o162, 12'o5560);       // JMP I through the return slot
        emit(12'o7200);
        emit(12'o4520);                     // JMS I
        emit(12'o7001);
        emit(12'o7402);
        model_run();
        run_to_halt();
        check_mem(12'o160);
        end_test("JMS through indirect pointer", e0);

        e0 = errors;
        loc = model_pc;
        draw(r);
        brk_write(12'o131, r);
        draw(r);
        brk_write(12'o133, r);
        brk_write(12'o130, 12'o133);
        emit(12'o7201);
        emit(12'o1131);
        emit(12'o3132);
        emit(12'o5000 | (loc + 12'd2));     // Jumps over the next word
        emit(12'o7402);
        emit(12'o1530);                     // TAD I
        emit(12'o7402);
        model_run();
        single_step = 1'b1;
        release_halt();
        for (int k = 0; k < trace_pc.size(); k++)
        begin
            for (int j = 0; j < trace_cyc[k]; j++)
                pulse_cont();
            check_val("pc", pc, trace_pc[k]);
        end
        check_true(halted, "halted did not rise after the last step");
        check_val("ac", ac, model_ac);
        single_step = 1'b0;
        check_mem(12'o132);
        end_test("single step", e0);

        e0 = errors;
        load_straight();
        model_run();
        fork
            run_to_halt();
            side_breaks();
        join
        check_straight();
        end_test("breaks during a run", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
common/pdp8_pkg.sv
sequencer/major_state.sv
rtl/cpu_datapath.sv
rtl/break_channel.sv
rtl/mem_arbiter.sv
rtl/core_mem.sv
rtl/pdp8_top.sv
tests/clock_gen.sv
tests/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJ_DIR)
